// ==== list.f ====
+incdir+logic
logic/dfpFormatPkg.sv
logic/dfpDivPkg.sv
logic/dfpDecode.sv
logic/dfpDigitDivider.sv
logic/dfpQuotientPack.sv
logic/dfpDivider.sv
verif/dfpDivider_sva.sv
verif/dfpDividerTb.sv

// ==== verif/dfpDividerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dfpDiv_cfg.svh"

module dfpDividerTb;

	import dfpFormatPkg::*;

	// worst case from ld to done, every digit a nine
	localparam int MAX_LAT = 10 * (`DFP_DIGITS + 1) + 4;
	localparam int NUM_RAND = 24;
	// random ops plus specials, extremes, unnormalized, restart and ce tests
	localparam int NUM_OPS = NUM_RAND + 24;
	localparam int LIMIT = NUM_OPS * MAX_LAT + 600;
	localparam longint TEN_D = 10 ** `DFP_DIGITS;

	localparam dfpWord finOp = '{sign: 1'b1, exp: dfpExp'(130), sig: dfpSig'('h3141592)};
	localparam dfpWord zeroOp = '{sign: 1'b0, exp: dfpExp'(120), sig: '0};
	localparam dfpWord infOp = '{sign: 1'b0, exp: dfpExpInf, sig: '0};
	localparam dfpWord nanOpA = '{sign: 1'b0, exp: dfpExpInf, sig: dfpSig'('h1234)};
	localparam dfpWord nanOpB = '{sign: 1'b1, exp: dfpExpInf, sig: dfpSig'('h77)};

	typedef struct packed {
		dfpWord word;
		dfpFlags flags;
	} refResult;

	logic clk;
	logic rst;
	logic ce;
	logic ld;
	dfpWord a;
	dfpWord b;
	dfpWord o;
	dfpFlags flags;
	logic done;

	logic [31:0] lfsr = 32'd69208;
	logic testOk;
	int testCount;
	int badTests;
	int cycles;

	dfpDivider i_dfpDivider (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(ld),
		.a(a),
		.b(b),
		.o(o),
		.flags(flags),
		.done(done)
	);

	always #5 clk = ~clk;

	// -------------------------------------------------------------------------
	// random operands
	// -------------------------------------------------------------------------

	// galois lfsr, x^32+x^22+x^2+x+1, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// values above nine fold back into 0..9
	function automatic dfpDigit randDigit();
		return dfpDigit'(takeBits(4) % 10);
	endfunction

	// normalized finite word, lowest zeroLow digits cleared
	function automatic dfpWord randFinite(input int zeroLow);
		dfpWord w;
		w.sign = takeBits(1) != 0;
		w.exp = dfpExp'(96 + takeBits(6));
		for (int i = 0; i < `DFP_DIGITS; i++) begin
			w.sig[i*4 +: 4] = (i < zeroLow) ? 4'h0 : randDigit();
		end
		if (w.sig[`DFP_SIG_W-1 -: 4] == 4'h0) begin
			w.sig[`DFP_SIG_W-1 -: 4] = 4'h1;
		end
		return w;
	endfunction

	// -------------------------------------------------------------------------
	// reference model
	// -------------------------------------------------------------------------
	function automatic longint sigValue(input dfpSig s);
		longint v;
		v = 0;
		for (int i = `DFP_DIGITS - 1; i >= 0; i--) begin
			v = v * 10 + s[i*4 +: 4];
		end
		return v;
	endfunction

	function automatic dfpSig sigFromValue(input longint v);
		dfpSig s;
		for (int i = 0; i < `DFP_DIGITS; i++) begin
			s[i*4 +: 4] = dfpDigit'(v % 10);
			v = v / 10;
		end
		return s;
	endfunction

	function automatic refResult refDivide(input dfpWord x, input dfpWord y);
		refResult r;
		logic xNan, xInf, xZero, yNan, yInf, yZero, s;
		longint ma, mb, q;
		int ea, eb, e;
		xNan = (x.exp == dfpExpInf) && (x.sig != '0);
		xInf = (x.exp == dfpExpInf) && (x.sig == '0);
		xZero = (x.exp != dfpExpInf) && (x.sig == '0);
		yNan = (y.exp == dfpExpInf) && (y.sig != '0);
		yInf = (y.exp == dfpExpInf) && (y.sig == '0);
		yZero = (y.exp != dfpExpInf) && (y.sig == '0);
		s = x.sign ^ y.sign;
		r.flags = '0;
		// finite/inf and 0/finite stay at signed zero
		r.word = '{sign: s, exp: '0, sig: '0};
		if (xNan) begin
			r.word = x;
		end else if (yNan) begin
			r.word = y;
		end else if ((xZero && yZero) || (xInf && yInf)) begin
			r.word = dfpQnan;
			r.flags.invalid = 1'b1;
		end else if (yZero && !xInf) begin
			r.word = '{sign: s, exp: dfpExpInf, sig: '0};
			r.flags.divByZero = 1'b1;
		end else if (xInf) begin
			r.word = '{sign: s, exp: dfpExpInf, sig: '0};
		end else if (!yInf && !xZero) begin
			ma = sigValue(x.sig);
			mb = sigValue(y.sig);
			ea = int'(x.exp);
			eb = int'(y.exp);
			while (ma < TEN_D / 10) begin
				ma = ma * 10;
				ea--;
			end
			while (mb < TEN_D / 10) begin
				mb = mb * 10;
				eb--;
			end
			q = ma * TEN_D / mb;
			e = ea - eb + `DFP_BIAS;
			// eight digits when a >= b, else seven and one decade less
			if (q >= TEN_D) begin
				q = q / 10;
			end else begin
				e--;
			end
			if (e > `DFP_EXP_MAX) begin
				r.word = '{sign: s, exp: dfpExpInf, sig: '0};
				r.flags.overflow = 1'b1;
			end else if (e < 0) begin
				r.flags.underflow = 1'b1;
			end else begin
				r.word = '{sign: s, exp: dfpExp'(e), sig: sigFromValue(q)};
			end
		end
		return r;
	endfunction

	// -------------------------------------------------------------------------
	// drive and check
	// -------------------------------------------------------------------------
	task automatic issueOp(input dfpWord x, input dfpWord y);
		@(posedge clk);
		ld <= 1'b1;
		a <= x;
		b <= y;
		@(posedge clk);
		ld <= 1'b0;
	endtask

	// lat counts clock cycles from the edge that drove ld
	task automatic waitDone(input int limit, output int lat, output bit seen);
		lat = 1;
		seen = 1'b0;
		while (!seen && lat <= limit) begin
			@(negedge clk);
			if (done) begin
				seen = 1'b1;
			end else begin
				lat++;
			end
		end
	endtask

	task automatic countDone(input int n, output int cnt);
		cnt = 0;
		repeat (n) begin
			@(negedge clk);
			if (done) begin
				cnt++;
			end
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (!testOk) begin
			badTests++;
		end
		$display("%-12s %s", name, testOk ? "ok" : "mismatch");
	endtask

	// expLat of zero leaves latency unchecked
	task automatic runOp(input string name, input dfpWord x, input dfpWord y,
			input refResult want, input int expLat);
		int lat;
		bit seen;
		testOk = 1'b1;
		issueOp(x, y);
		waitDone(MAX_LAT + 2, lat, seen);
		assert (seen) else begin
			$display("%s: done never arrived", name);
			testOk = 1'b0;
		end
		assert (!seen || o === want.word) else begin
			$display("FAILED %s: expected o %h actual %h", name, want.word, o);
			testOk = 1'b0;
		end
		assert (!seen || flags === want.flags) else begin
			$display("FAILED %s: expected flags %b actual %b", name, want.flags, flags);
			testOk = 1'b0;
		end
		assert (!seen || expLat == 0 || lat == expLat) else begin
			$display("FAILED %s: expected latency %0d actual %0d", name, expLat, lat);
			testOk = 1'b0;
		end
		endTest(name);
	endtask

	initial begin
		int cnt;
		int extra;
		int lat;
		int svaErrors;
		bit seen;
		dfpWord x;
		dfpWord y;
		dfpWord held;
		refResult want;
		clk = 1'b0;
		rst = 1'b1;
		ce = 1'b1;
		ld = 1'b0;
		a = '0;
		b = '0;
		testCount = 0;
		badTests = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < NUM_RAND; i++) begin
			x = randFinite(0);
			y = randFinite(0);
			runOp($sformatf("rand%0d", i), x, y, refDivide(x, y), 0);
		end

		// specials resolve in decode, done two cycles after ld
		runOp("nanA", nanOpA, nanOpB, refDivide(nanOpA, nanOpB), 2);
		runOp("nanB", finOp, nanOpB, refDivide(finOp, nanOpB), 2);
		runOp("zeroZero", zeroOp, zeroOp, refDivide(zeroOp, zeroOp), 2);
		runOp("infInf", infOp, infOp, refDivide(infOp, infOp), 2);
		runOp("divZero", finOp, zeroOp, refDivide(finOp, zeroOp), 2);
		runOp("infFin", infOp, finOp, refDivide(infOp, finOp), 2);
		runOp("infZero", infOp, zeroOp, refDivide(infOp, zeroOp), 2);
		runOp("finInf", finOp, infOp, refDivide(finOp, infOp), 2);
		runOp("zeroFin", zeroOp, finOp, refDivide(zeroOp, finOp), 2);

		// exponent extremes
		x = '{sign: 1'b0, exp: dfpExp'(250), sig: dfpSig'('h5000000)};
		y = '{sign: 1'b1, exp: dfpExp'(10), sig: dfpSig'('h2000000)};
		runOp("overflow", x, y, refDivide(x, y), 0);
		runOp("underflow", y, x, refDivide(y, x), 0);

		// leading zero digits with a compensating exponent
		for (int k = 1; k <= 4; k++) begin
			x = randFinite(k);
			y = randFinite(2);
			want = refDivide(x, y);
			x.sig = x.sig >> (4 * k);
			x.exp = x.exp + dfpExp'(k);
			y.sig = y.sig >> 8;
			y.exp = y.exp + dfpExp'(2);
			runOp($sformatf("unnorm%0d", k), x, y, want, 0);
		end

		// second ld while the first division runs
		x = randFinite(0);
		y = randFinite(0);
		issueOp(x, y);
		countDone(5, cnt);
		x = randFinite(0);
		y = randFinite(0);
		runOp("restart", x, y, refDivide(x, y), 0);
		countDone(MAX_LAT + 4, extra);
		testOk = 1'b1;
		assert (cnt + extra == 0) else begin
			$display("restartOnce: abandoned operation gave %0d extra done", cnt + extra);
			testOk = 1'b0;
		end
		endTest("restartOnce");

		// ld while ce is low is dropped and nothing moves
		testOk = 1'b1;
		held = o;
		@(posedge clk);
		ce <= 1'b0;
		x = randFinite(0);
		y = randFinite(0);
		issueOp(x, y);
		countDone(20, cnt);
		assert (cnt == 0) else begin
			$display("ceHold: done pulsed %0d times with ce low", cnt);
			testOk = 1'b0;
		end
		assert (o === held) else begin
			$display("FAILED ceHold: expected o %h actual %h", held, o);
			testOk = 1'b0;
		end
		@(posedge clk);
		ce <= 1'b1;
		countDone(MAX_LAT + 4, cnt);
		assert (cnt == 0) else begin
			$display("ceHold: ld issued with ce low was not ignored");
			testOk = 1'b0;
		end
		endTest("ceHold");

		// stall in the middle of a division
		x = randFinite(0);
		y = randFinite(0);
		want = refDivide(x, y);
		testOk = 1'b1;
		issueOp(x, y);
		countDone(6, cnt);
		held = o;
		@(posedge clk);
		ce <= 1'b0;
		countDone(15, extra);
		assert (cnt + extra == 0 && o === held) else begin
			$display("ceStall: output moved before or during the stall");
			testOk = 1'b0;
		end
		@(posedge clk);
		ce <= 1'b1;
		waitDone(MAX_LAT + 2, lat, seen);
		assert (seen) else begin
			$display("ceStall: done never arrived after the stall");
			testOk = 1'b0;
		end
		assert (!seen || (o === want.word && flags === want.flags)) else begin
			$display("FAILED ceStall: expected %h/%b actual %h/%b",
				want.word, want.flags, o, flags);
			testOk = 1'b0;
		end
		endTest("ceStall");

		svaErrors = i_dfpDivider.i_dfpDividerSva.errCount;
		$display("tests %0d, passed %0d, failed %0d, bound assertion failures %0d",
			testCount, testCount - badTests, badTests, svaErrors);
		if (badTests == 0 && svaErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, done never arrived", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/dfpDivider_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dfpDiv_cfg.svh"

module dfpDividerSva (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic ld,
	input dfpFormatPkg::dfpWord o,
	input dfpFormatPkg::dfpFlags flags,
	input wire logic done
);

	import dfpFormatPkg::*;

	localparam int MAX_LAT = 10 * (`DFP_DIGITS + 1) + 4;

	int errCount = 0;
	// enabled cycles since the last accepted ld
	int waitCnt;
	logic busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			waitCnt <= 0;
		end else if (ce) begin
			if (ld) begin
				busy <= 1'b1;
				waitCnt <= 0;
			end else if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				waitCnt <= waitCnt + 1;
			end
		end
	end

	// one enabled cycle of done per completion
	doneSingle: assert property (@(posedge clk) disable iff (rst) (ce && done) |=> !done)
		else begin
			$error("done high on two enabled cycles in a row");
			errCount++;
		end

	overflowInf: assert property (@(posedge clk) disable iff (rst)
		flags.overflow |-> (o.exp == dfpExpInf && o.sig == '0))
		else begin
			$error("overflow raised but o is not an infinity");
			errCount++;
		end

	divZeroInf: assert property (@(posedge clk) disable iff (rst)
		flags.divByZero |-> (o.exp == dfpExpInf && o.sig == '0))
		else begin
			$error("divByZero raised but o is not an infinity");
			errCount++;
		end

	invalidNan: assert property (@(posedge clk) disable iff (rst) flags.invalid |-> o == dfpQnan)
		else begin
			$error("invalid raised but o is not the canonical nan");
			errCount++;
		end

	// a restart resets the count
	latencyBound: assert property (@(posedge clk) disable iff (rst) busy |-> waitCnt <= MAX_LAT)
		else begin
			$error("done did not follow ld within %0d enabled cycles", MAX_LAT);
			errCount++;
		end

	resetClear: assert property (@(posedge clk) rst |=> (!done && flags == '0 && o == '0))
		else begin
			$error("outputs not cleared by reset");
			errCount++;
		end

endmodule

bind dfpDivider dfpDividerSva i_dfpDividerSva (
	.clk(clk),
	.rst(rst),
	.ce(ce),
	.ld(ld),
	.o(o),
	.flags(flags),
	.done(done)
);

`default_nettype wire

// ==== logic/dfpDivider.sv ====
`timescale 1ns/1ps
`default_nettype none

module dfpDivider (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic ld,
	input dfpFormatPkg::dfpWord a,
	input dfpFormatPkg::dfpWord b,
	output dfpFormatPkg::dfpWord o,
	output dfpFormatPkg::dfpFlags flags,
	output logic done
);

	import dfpDivPkg::*;

	// decode to execute and result
	logic divStart;
	dfpDivOp divOp;
	logic specValid;
	dfpSpecial spec;

	// execute to result
	logic qValid;
	dfpQuot quot;

	// -------------------------------------------------------------------------
	// stages
	// -------------------------------------------------------------------------
	dfpDecode i_decode (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(ld),
		.a(a),
		.b(b),
		.divStart(divStart),
		.divOp(divOp),
		.specValid(specValid),
		.spec(spec)
	);

	dfpDigitDivider i_execute (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.divStart(divStart),
		.sigA(divOp.sigA),
		.sigB(divOp.sigB),
		.qValid(qValid),
		.quot(quot)
	);

	dfpQuotientPack i_result (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.divStart(divStart),
		.divOp(divOp),
		.specValid(specValid),
		.spec(spec),
		.qValid(qValid),
		.quot(quot),
		.o(o),
		.flags(flags),
		.done(done)
	);

endmodule

`default_nettype wire

// ==== logic/dfpQuotientPack.sv ====
`timescale 1ns/1ps
`default_nettype none

module dfpQuotientPack (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic divStart,
	input dfpDivPkg::dfpDivOp divOp,
	input wire logic specValid,
	input dfpDivPkg::dfpSpecial spec,
	input wire logic qValid,
	input dfpDivPkg::dfpQuot quot,
	output dfpFormatPkg::dfpWord o,
	output dfpFormatPkg::dfpFlags flags,
	output logic done
);

	import dfpFormatPkg::*;
	import dfpDivPkg::*;

	localparam int QW = $bits(dfpQuot);
	localparam dfpExpWide EXP_MAX_W = dfpExpWide'({2'b00, dfpExpMax});

	// exponent and sign of the division in flight
	dfpExpWide expLatch;
	logic signLatch;
	// a division is outstanding and its quotient is wanted
	logic pending;

	dfpDigit leadDigit;
	dfpExpWide qExp;
	dfpSig qSig;
	dfpWord qWord;
	dfpFlags qFlags;

	// -------------------------------------------------------------------------
	// normalize, truncate and range check
	// -------------------------------------------------------------------------
	assign leadDigit = quot[QW-1 -: 4];

	always_comb begin
		qFlags = '0;
		// zero lead digit means a/b below one
		if (leadDigit == 4'h0) begin
			qExp = expLatch - dfpExpWide'(1);
			qSig = quot[QW-5:0];
		end else begin
			qExp = expLatch;
			qSig = quot[QW-1:4];
		end
		qWord = '{sign: signLatch, exp: qExp[$bits(dfpExp)-1:0], sig: qSig};
		if (qExp > EXP_MAX_W) begin
			qWord = '{sign: signLatch, exp: dfpExpInf, sig: '0};
			qFlags.overflow = 1'b1;
		end else if (qExp < 0) begin
			// flush to signed zero
			qWord = '{sign: signLatch, exp: '0, sig: '0};
			qFlags.underflow = 1'b1;
		end
	end

	// -------------------------------------------------------------------------
	// output registers
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (ce && divStart) begin
			expLatch <= divOp.expDiff;
			signLatch <= divOp.sign;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o <= '0;
			flags <= '0;
			done <= 1'b0;
			pending <= 1'b0;
		end else if (ce) begin
			done <= 1'b0;
			if (divStart) begin
				pending <= 1'b1;
			end else if (specValid) begin
				// a special result also cancels any running division
				o <= spec.word;
				flags <= spec.flags;
				done <= 1'b1;
				pending <= 1'b0;
			end else if (qValid && pending) begin
				o <= qWord;
				flags <= qFlags;
				done <= 1'b1;
				pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/dfpDigitDivider.sv ====
`timescale 1ns/1ps
`default_nettype none

module dfpDigitDivider (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic divStart,
	input dfpFormatPkg::dfpSig sigA,
	input dfpFormatPkg::dfpSig sigB,
	output logic qValid,
	output dfpDivPkg::dfpQuot quot
);

	import dfpFormatPkg::*;
	import dfpDivPkg::*;

	// quotient digit count and counter width
	localparam int QDIGITS = $bits(dfpQuot) / 4;
	localparam int CNT_W = $clog2(QDIGITS);

	dfpExecState state;
	// partial remainder, always below 10 * divisor
	dfpRem rem;
	// divisor widened to remainder size
	dfpRem divisor;
	// digit under construction
	dfpDigit digit;
	// index of that digit, 0 is the leading one
	logic [CNT_W-1:0] cnt;
	logic remGe;

	assign remGe = bcdGe(rem, divisor);

	// quotient is final while in execDone
	assign qValid = (state == execDone);

	// -------------------------------------------------------------------------
	// control
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= execIdle;
			cnt <= '0;
		end else if (ce) begin
			// a new start abandons whatever is running
			if (divStart) begin
				state <= execStep;
				cnt <= '0;
			end else begin
				case (state)
					execStep: begin
						// closing a digit
						if (!remGe) begin
							if (cnt == CNT_W'(QDIGITS - 1)) begin
								state <= execDone;
							end else begin
								cnt <= cnt + 1'b1;
							end
						end
					end
					execDone: begin
						state <= execIdle;
					end
					default: begin
						state <= execIdle;
					end
				endcase
			end
		end
	end

	// -------------------------------------------------------------------------
	// datapath
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (ce) begin
			if (divStart) begin
				// first dividend chunk is all of sigA, the rest are zeros
				rem <= {4'h0, sigA};
				divisor <= {4'h0, sigB};
				digit <= 4'h0;
				quot <= '0;
			end else if (state == execStep) begin
				if (remGe) begin
					// one more subtraction fits
					rem <= bcdSub(rem, divisor);
					digit <= digit + 4'h1;
				end else begin
					// store digit, next dividend digit is zero
					quot <= bcdShiftIn(quot, digit);
					rem <= bcdShiftIn(rem, 4'h0);
					digit <= 4'h0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/dfpDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dfpDiv_cfg.svh"

module dfpDecode (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic ld,
	input dfpFormatPkg::dfpWord a,
	input dfpFormatPkg::dfpWord b,
	output logic divStart,
	output dfpDivPkg::dfpDivOp divOp,
	output logic specValid,
	output dfpDivPkg::dfpSpecial spec
);

	import dfpFormatPkg::*;
	import dfpDivPkg::*;

	localparam int LZ_W = $clog2(`DFP_DIGITS + 1);

	// leading zero digits, DFP_DIGITS for a zero significand
	function automatic logic [LZ_W-1:0] leadZeros(input dfpSig s);
		logic [LZ_W-1:0] n;
		logic seen;
		n = '0;
		seen = 1'b0;
		for (int i = `DFP_DIGITS - 1; i >= 0; i--) begin
			if (s[i*4 +: 4] != 4'h0) begin
				seen = 1'b1;
			end
			if (!seen) begin
				n = n + 1'b1;
			end
		end
		return n;
	endfunction

	// -------------------------------------------------------------------------
	// classify
	// -------------------------------------------------------------------------
	logic aNan, aInf, aZero;
	logic bNan, bInf, bZero;
	logic signQ;
	logic [LZ_W-1:0] lzA, lzB;
	dfpExpWide effA, effB;
	dfpDivOp opNext;
	dfpSpecial specNext;
	logic isSpecial;

	assign aNan = (a.exp == dfpExpInf) && (a.sig != '0);
	assign aInf = (a.exp == dfpExpInf) && (a.sig == '0);
	assign aZero = (a.exp != dfpExpInf) && (a.sig == '0);
	assign bNan = (b.exp == dfpExpInf) && (b.sig != '0);
	assign bInf = (b.exp == dfpExpInf) && (b.sig == '0);
	assign bZero = (b.exp != dfpExpInf) && (b.sig == '0);
	assign signQ = a.sign ^ b.sign;

	// normalize: shift leading zeros out and move the exponent down
	assign lzA = leadZeros(a.sig);
	assign lzB = leadZeros(b.sig);
	assign effA = dfpExpWide'({2'b00, a.exp}) - dfpExpWide'(lzA);
	assign effB = dfpExpWide'({2'b00, b.exp}) - dfpExpWide'(lzB);

	assign opNext.sigA = a.sig << {lzA, 2'b00};
	assign opNext.sigB = b.sig << {lzB, 2'b00};
	assign opNext.sign = signQ;
	assign opNext.expDiff = effA - effB + dfpExpWide'(`DFP_BIAS);

	// -------------------------------------------------------------------------
	// special cases, first match wins
	// -------------------------------------------------------------------------
	always_comb begin
		specNext.flags = '0;
		// signed zero unless a rule below says otherwise
		specNext.word = '{sign: signQ, exp: '0, sig: '0};
		isSpecial = 1'b1;
		// format has no signalling nans so a nan passes unchanged
		if (aNan) begin
			specNext.word = a;
		end else if (bNan) begin
			specNext.word = b;
		end else if ((aZero && bZero) || (aInf && bInf)) begin
			specNext.word = dfpQnan;
			specNext.flags.invalid = 1'b1;
		end else if (bZero && !aInf) begin
			specNext.word = '{sign: signQ, exp: dfpExpInf, sig: '0};
			specNext.flags.divByZero = 1'b1;
		end else if (aInf) begin
			// inf over anything finite, zero included
			specNext.word = '{sign: signQ, exp: dfpExpInf, sig: '0};
		end else if (!(bInf || aZero)) begin
			// both finite and nonzero, real division
			isSpecial = 1'b0;
		end
	end

	// operands and strobes, one cycle after ld
	always_ff @(posedge clk) begin
		if (rst) begin
			divStart <= 1'b0;
			specValid <= 1'b0;
		end else if (ce) begin
			divStart <= ld && !isSpecial;
			specValid <= ld && isSpecial;
		end
	end

	always_ff @(posedge clk) begin
		if (ce && ld) begin
			divOp <= opNext;
			spec <= specNext;
		end
	end

endmodule

`default_nettype wire

// ==== logic/dfpDivPkg.sv ====
`default_nettype none

`include "dfpDiv_cfg.svh"

package dfpDivPkg;

	import dfpFormatPkg::*;

	// -------------------------------------------------------------------------
	// internal types
	// -------------------------------------------------------------------------

	// signed exponent for differences and range checks
	typedef logic signed [`DFP_EXPW_W-1:0] dfpExpWide;

	// partial remainder, one digit wider than the significand
	typedef logic [`DFP_QUOT_W-1:0] dfpRem;

	// quotient digits q0 q1 ... q(DFP_DIGITS)
	typedef logic [`DFP_QUOT_W-1:0] dfpQuot;

	// operands handed from decode to execute and result
	typedef struct packed {
		dfpSig sigA;
		dfpSig sigB;
		logic sign;
		dfpExpWide expDiff;
	} dfpDivOp;

	// fully resolved special result
	typedef struct packed {
		dfpWord word;
		dfpFlags flags;
	} dfpSpecial;

	// execute fsm
	typedef enum logic [1:0] {
		execIdle,
		execStep,
		execDone
	} dfpExecState;

	// -------------------------------------------------------------------------
	// bcd arithmetic
	// -------------------------------------------------------------------------

	// digit serial subtract x - y, caller guarantees x >= y
	function automatic dfpRem bcdSub(input dfpRem x, input dfpRem y);
		dfpRem diff;
		logic borrow;
		logic [4:0] d;
		borrow = 1'b0;
		for (int i = 0; i < $bits(dfpRem) / 4; i++) begin
			d = {1'b0, x[i*4 +: 4]} - {1'b0, y[i*4 +: 4]} - {4'h0, borrow};
			borrow = d[4];
			// negative digit wraps back into 0..9
			if (borrow) begin
				d = d + 5'd10;
			end
			diff[i*4 +: 4] = d[3:0];
		end
		return diff;
	endfunction

	// valid packed bcd orders the same way as binary
	function automatic logic bcdGe(input dfpRem x, input dfpRem y);
		return x >= y;
	endfunction

	// multiply by ten and bring in a new low digit
	function automatic dfpRem bcdShiftIn(input dfpRem x, input dfpDigit d);
		return {x[$bits(dfpRem)-5:0], d};
	endfunction

endpackage

`default_nettype wire

// ==== logic/dfpFormatPkg.sv ====
`default_nettype none

`include "dfpDiv_cfg.svh"

package dfpFormatPkg;

	// -------------------------------------------------------------------------
	// field types
	// -------------------------------------------------------------------------

	// one bcd digit
	typedef logic [3:0] dfpDigit;

	// significand, d0 in the top nibble
	typedef logic [`DFP_SIG_W-1:0] dfpSig;

	// biased exponent
	typedef logic [`DFP_EXP_W-1:0] dfpExp;

	// operand and result word
	typedef struct packed {
		logic sign;
		dfpExp exp;
		dfpSig sig;
	} dfpWord;

	// exception flags reported with each result
	typedef struct packed {
		logic invalid;
		logic divByZero;
		logic overflow;
		logic underflow;
	} dfpFlags;

	// -------------------------------------------------------------------------
	// canonical constants
	// -------------------------------------------------------------------------

	// exponent of inf and nan
	localparam dfpExp dfpExpInf = '1;
	// largest exponent of a finite value
	localparam dfpExp dfpExpMax = dfpExp'(`DFP_EXP_MAX);

	// canonical nan, positive with significand 0...01
	localparam dfpWord dfpQnan = '{sign: 1'b0, exp: dfpExpInf, sig: dfpSig'(1)};

endpackage

`default_nettype wire

// ==== logic/dfpDiv_cfg.svh ====
`ifndef DFP_DIV_CFG_SVH
`define DFP_DIV_CFG_SVH

// bcd digits in the significand
`define DFP_DIGITS 7

// biased binary exponent
`define DFP_EXP_W 8
`define DFP_BIAS 127
// all ones is reserved for inf and nan
`define DFP_EXP_MAX 254

// derived widths
`define DFP_SIG_W (4 * `DFP_DIGITS)
// quotient and remainder carry one extra digit
`define DFP_QUOT_W (4 * (`DFP_DIGITS + 1))
// intermediate exponents are signed with two guard bits
`define DFP_EXPW_W (`DFP_EXP_W + 2)

`endif
